//--- radio_ctrl_core.f
source/ctrl_pkg.sv
source/ctrl_cmd_engine.sv
source/misc_config.sv
source/time_keeper.sv
source/gpio_atr.sv
source/radio_ctrl_core.sv
tb/radio_ctrl_core_assert.sv
tb/radio_ctrl_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the radio_ctrl_core testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
   --top-module radio_ctrl_core_tb \
   -Mdir "$OBJ" \
   -f radio_ctrl_core.f

# Keep running past assertion errors so the testbench prints its summary
"./$OBJ/Vradio_ctrl_core_tb" +verilator+error+limit+100 2>&1 | tee "$LOG"

if grep -q "^PASS: all tests$" "$LOG"; then
   echo "simulation passed"
else
   echo "simulation failed, see $LOG"
   exit 1
fi

//--- source/ctrl_cmd_engine.sv
`timescale 1ns/1ps

module ctrl_cmd_engine import ctrl_pkg::*; #(
   parameter logic [31:0] COMPAT_NUM = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        reset_i,
   // Command stream in
   input  logic [35:0] cmd_data_i,
   input  logic        cmd_valid_i,
   output logic        cmd_ready_o,
   // Response stream out
   output logic [35:0] resp_data_o,
   output logic        resp_valid_o,
   input  logic        resp_ready_i,
   // Settings bus
   output logic        set_stb_o,
   output logic [7:0]  set_addr_o,
   output logic [31:0] set_data_o,
   // Readback sources
   input  logic [31:0] gpio_rb_i,
   input  logic [31:0] config0_i,
   input  logic [31:0] config1_i,
   input  logic [63:0] pps_time_i,
   input  logic [63:0] vita_time_i
);

   localparam logic [2:0] S_WAIT_SOF = 3'd0;
   localparam logic [2:0] S_WAIT_EOF = 3'd1;
   localparam logic [2:0] S_ACT      = 3'd2;
   localparam logic [2:0] S_HDR      = 3'd3;
   localparam logic [2:0] S_DATA     = 3'd4;

   logic [2:0]  state;
   ctrl_word_u  cmd_word;
   logic [31:0] rb_mux;
   logic [31:0] resp_val;
   logic [31:0] rb_word;
   logic [31:0] time_lo_snap;
   logic        cmd_accept;
   logic        eof_accept;
   logic        is_write;
   logic        is_read;

   // Only one packet in flight, input stalls while responding
   assign cmd_ready_o  = (state == S_WAIT_SOF) || (state == S_WAIT_EOF);
   assign cmd_accept   = cmd_valid_i && cmd_ready_o;
   assign eof_accept   = cmd_accept && (state == S_WAIT_EOF) && cmd_data_i[LINE_EOF];
   assign resp_valid_o = (state == S_ACT) || (state == S_HDR) || (state == S_DATA);

   assign is_write = (cmd_word.wr.op == OP_WRITE);
   assign is_read  = (cmd_word.rd.op == OP_READ);

   ////////////////////////////////////////////////////////////////////////////
   // Readback selection
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (cmd_word.rd.rb_sel)
         RB_COMPAT:  rb_mux = COMPAT_NUM;
         RB_GPIO:    rb_mux = gpio_rb_i;
         RB_CONFIG0: rb_mux = config0_i;
         RB_CONFIG1: rb_mux = config1_i;
         // High half now, low half held for the next read
         RB_TIME_HI: rb_mux = vita_time_i[63:32];
         RB_TIME_LO: rb_mux = time_lo_snap;
         RB_PPS_HI:  rb_mux = pps_time_i[63:32];
         RB_PPS_LO:  rb_mux = pps_time_i[31:0];
         default:    rb_mux = '1;
      endcase
   end

   // Writes answer zero, unknown ops all ones
   always_comb begin
      if (is_read) begin
         resp_val = rb_mux;
      end else if (is_write) begin
         resp_val = '0;
      end else begin
         resp_val = '1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Packet FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state     <= S_WAIT_SOF;
         set_stb_o <= 1'b0;
      end else begin
         set_stb_o <= 1'b0;
         case (state)
            S_WAIT_SOF: begin
               // Stray lines without SOF fall through here
               if (cmd_accept && cmd_data_i[LINE_SOF]) begin
                  state <= S_WAIT_EOF;
               end
            end
            S_WAIT_EOF: begin
               if (eof_accept) begin
                  state     <= S_ACT;
                  set_stb_o <= is_write;
               end
            end
            S_ACT: begin
               state <= resp_ready_i ? S_DATA : S_HDR;
            end
            S_HDR: begin
               if (resp_ready_i) begin
                  state <= S_DATA;
               end
            end
            S_DATA: begin
               if (resp_ready_i) begin
                  state <= S_WAIT_SOF;
               end
            end
            default: begin
               state <= S_WAIT_SOF;
            end
         endcase
      end
   end

   // Command capture, bus payload and readback sample
   always_ff @(posedge clk) begin
      if (cmd_accept && cmd_data_i[LINE_SOF]) begin
         cmd_word <= cmd_data_i[31:0];
      end
      if (eof_accept) begin
         set_addr_o <= cmd_word.wr.addr;
         set_data_o <= cmd_data_i[31:0];
      end
      if (state == S_ACT) begin
         rb_word <= resp_val;
         if (is_read && (cmd_word.rd.rb_sel == RB_TIME_HI)) begin
            time_lo_snap <= vita_time_i[31:0];
         end
      end
   end

   // Header echoes op and seq, data line carries the readback
   always_comb begin
      resp_data_o = '0;
      if (state == S_DATA) begin
         resp_data_o[LINE_EOF] = 1'b1;
         resp_data_o[31:0]     = rb_word;
      end else begin
         resp_data_o[LINE_SOF] = 1'b1;
         resp_data_o[31:16]    = {cmd_word.wr.op, cmd_word.wr.seq};
      end
   end

endmodule

//--- source/ctrl_pkg.sv
package ctrl_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus base addresses
   ////////////////////////////////////////////////////////////////////////////

   // Misc block, offsets 0 to 2
   localparam logic [7:0] SR_MISC   = 8'd0;
   // Timekeeper, offsets 0 to 2
   localparam logic [7:0] SR_TIME64 = 8'd192;
   // ATR GPIO bank, offsets 0 to 4
   localparam logic [7:0] SR_GPIO   = 8'd224;

   ////////////////////////////////////////////////////////////////////////////
   // Readback word indices
   ////////////////////////////////////////////////////////////////////////////

   localparam logic [3:0] RB_COMPAT  = 4'd0;
   localparam logic [3:0] RB_GPIO    = 4'd1;
   localparam logic [3:0] RB_CONFIG0 = 4'd2;
   localparam logic [3:0] RB_CONFIG1 = 4'd3;
   localparam logic [3:0] RB_TIME_HI = 4'd4;
   localparam logic [3:0] RB_TIME_LO = 4'd5;
   localparam logic [3:0] RB_PPS_HI  = 4'd6;
   localparam logic [3:0] RB_PPS_LO  = 4'd7;

   // Flag bits of a 36 bit stream line, bits 35:34 stay zero
   localparam int LINE_SOF = 32;
   localparam int LINE_EOF = 33;

   // Command opcodes
   localparam logic [1:0] OP_WRITE = 2'd1;
   localparam logic [1:0] OP_READ  = 2'd2;

   // Command word, seen as a settings write or as a readback request
   typedef union packed {
      struct packed {
         logic [1:0]  op;
         logic [13:0] seq;
         logic [7:0]  addr;
         logic [7:0]  rsvd;
      } wr;
      struct packed {
         logic [1:0]  op;
         logic [13:0] seq;
         logic [3:0]  rb_sel;
         logic [11:0] rsvd;
      } rd;
   } ctrl_word_u;

endpackage

//--- source/gpio_atr.sv
`timescale 1ns/1ps

module gpio_atr import ctrl_pkg::*; #(
   parameter int GPIO_WIDTH = 16
) (
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic                  set_stb_i,
   input  logic [7:0]            set_addr_i,
   input  logic [31:0]           set_data_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic [GPIO_WIDTH-1:0] gpio_i,
   output logic [GPIO_WIDTH-1:0] gpio_o,
   output logic [GPIO_WIDTH-1:0] gpio_oe_o,
   output logic [31:0]           gpio_rb_o
);

   // Idle, rx only, tx only, full duplex
   logic [GPIO_WIDTH-1:0] atr_state [4];
   logic [7:0]            gpio_off;
   logic [1:0]            atr_sel;

   assign gpio_off = set_addr_i - SR_GPIO;
   assign atr_sel  = {run_tx_i, run_rx_i};

   always_ff @(posedge clk) begin
      if (set_stb_i && (gpio_off < 8'd4)) begin
         atr_state[gpio_off[1:0]] <= set_data_i[GPIO_WIDTH-1:0];
      end
   end

   // Direction mask, one bit per pin
   always_ff @(posedge clk) begin
      if (reset_i) begin
         gpio_oe_o <= '0;
      end else if (set_stb_i && (gpio_off == 8'd4)) begin
         gpio_oe_o <= set_data_i[GPIO_WIDTH-1:0];
      end
   end

   // Output follows the current run levels
   always_ff @(posedge clk) begin
      gpio_o <= atr_state[atr_sel];
   end

   // Input readback, zero extended
   always_ff @(posedge clk) begin
      gpio_rb_o <= 32'(gpio_i);
   end

endmodule

//--- source/misc_config.sv
`timescale 1ns/1ps

module misc_config import ctrl_pkg::*; (
   input  logic        clk,
   input  logic        reset_i,
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   input  logic        pps_i,
   output logic [31:0] config0_o,
   output logic [31:0] config1_o,
   output logic        clock_sync_o
);

   localparam logic [7:0] ADDR_CONFIG0 = SR_MISC + 8'd0;
   localparam logic [7:0] ADDR_CONFIG1 = SR_MISC + 8'd1;
   localparam logic [7:0] ADDR_SYNC    = SR_MISC + 8'd2;

   logic sync_enb;
   logic sync_inv;

   // Config words survive a core reset
   always_ff @(posedge clk) begin
      if (set_stb_i && (set_addr_i == ADDR_CONFIG0)) begin
         config0_o <= set_data_i;
      end
      if (set_stb_i && (set_addr_i == ADDR_CONFIG1)) begin
         config1_o <= set_data_i;
      end
   end

   // Clock sync control, bit 0 enable and bit 1 invert
   always_ff @(posedge clk) begin
      if (reset_i) begin
         sync_enb <= 1'b0;
         sync_inv <= 1'b0;
      end else if (set_stb_i && (set_addr_i == ADDR_SYNC)) begin
         sync_enb <= set_data_i[0];
         sync_inv <= set_data_i[1];
      end
   end

   // Raw PPS pin forwarded, no synchronizer on this path
   assign clock_sync_o = sync_enb ? (pps_i ^ sync_inv) : 1'b0;

endmodule

//--- source/radio_ctrl_core.sv
`timescale 1ns/1ps

module radio_ctrl_core #(
   parameter int          GPIO_WIDTH = 16,
   parameter logic [31:0] COMPAT_NUM = 32'h000b_0002
) (
   input  logic                  clk,
   input  logic                  reset_i,
   // Host command and response streams
   input  logic [35:0]           cmd_data_i,
   input  logic                  cmd_valid_i,
   output logic                  cmd_ready_o,
   output logic [35:0]           resp_data_o,
   output logic                  resp_valid_o,
   input  logic                  resp_ready_i,
   // Timing and run levels
   input  logic                  pps_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   // GPIO bank
   input  logic [GPIO_WIDTH-1:0] gpio_i,
   output logic [GPIO_WIDTH-1:0] gpio_o,
   output logic [GPIO_WIDTH-1:0] gpio_oe_o,
   output logic                  clock_sync_o,
   output logic [63:0]           vita_time_o
);

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus and readback wiring
   ////////////////////////////////////////////////////////////////////////////

   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   logic [31:0] gpio_rb;
   logic [31:0] config0;
   logic [31:0] config1;
   logic [63:0] pps_time;

   ctrl_cmd_engine #(.COMPAT_NUM(COMPAT_NUM)) ctrl_cmd_engine_i (
      .clk(clk), .reset_i(reset_i),
      .cmd_data_i(cmd_data_i), .cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o),
      .resp_data_o(resp_data_o), .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .gpio_rb_i(gpio_rb), .config0_i(config0), .config1_i(config1),
      .pps_time_i(pps_time), .vita_time_i(vita_time_o)
   );

   misc_config misc_config_i (
      .clk(clk), .reset_i(reset_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .config0_o(config0), .config1_o(config1),
      .clock_sync_o(clock_sync_o)
   );

   time_keeper time_keeper_i (
      .clk(clk), .reset_i(reset_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time_o), .pps_time_o(pps_time)
   );

   gpio_atr #(.GPIO_WIDTH(GPIO_WIDTH)) gpio_atr_i (
      .clk(clk), .reset_i(reset_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o), .gpio_rb_o(gpio_rb)
   );

endmodule

//--- source/time_keeper.sv
`timescale 1ns/1ps

module time_keeper import ctrl_pkg::*; (
   input  logic        clk,
   input  logic        reset_i,
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   input  logic        pps_i,
   output logic [63:0] vita_time_o,
   output logic [63:0] pps_time_o
);

   localparam logic [7:0] ADDR_TIME_HI = SR_TIME64 + 8'd0;
   localparam logic [7:0] ADDR_TIME_LO = SR_TIME64 + 8'd1;
   localparam logic [7:0] ADDR_CTRL    = SR_TIME64 + 8'd2;

   logic [1:0]  pps_sync;
   logic        pps_prev;
   logic        pps_edge;
   logic [31:0] time_hi_stage;
   logic [31:0] time_lo_stage;
   logic        armed;
   logic        ctrl_wr;
   logic        load_now;
   logic        load_pps;
   logic [63:0] time_next;

   assign ctrl_wr  = set_stb_i && (set_addr_i == ADDR_CTRL);
   assign load_now = ctrl_wr && set_data_i[0];
   assign pps_edge = pps_sync[1] && !pps_prev;
   assign load_pps = pps_edge && armed;

   // Value the counter takes at the coming edge
   assign time_next = (load_now || load_pps) ? {time_hi_stage, time_lo_stage}
                                             : vita_time_o + 64'd1;

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         pps_sync <= 2'b00;
         pps_prev <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_prev <= pps_sync[1];
      end
   end

   // Staged load value
   always_ff @(posedge clk) begin
      if (set_stb_i && (set_addr_i == ADDR_TIME_HI)) begin
         time_hi_stage <= set_data_i;
      end
      if (set_stb_i && (set_addr_i == ADDR_TIME_LO)) begin
         time_lo_stage <= set_data_i;
      end
   end

   // Bit 0 clear arms a load at the next PPS edge
   always_ff @(posedge clk) begin
      if (reset_i) begin
         armed <= 1'b0;
      end else if (ctrl_wr) begin
         armed <= !set_data_i[0];
      end else if (load_pps) begin
         armed <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Counter and PPS latch
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         vita_time_o <= '0;
         pps_time_o  <= '0;
      end else begin
         vita_time_o <= time_next;
         // Snapshot includes any armed load
         if (pps_edge) begin
            pps_time_o <= time_next;
         end
      end
   end

endmodule

//--- tb/radio_ctrl_core_assert.sv
`timescale 1ns/1ps

module radio_ctrl_core_assert (
   input logic        clk,
   input logic        reset_i,
   input logic        cmd_ready_i,
   input logic [35:0] resp_data_i,
   input logic        resp_valid_i,
   input logic        resp_ready_i,
   input logic        set_stb_i
);

   // Read back by the testbench summary
   int assert_fails = 0;

   // A stalled response line holds still
   resp_hold: assert property (@(posedge clk) disable iff (reset_i)
      resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
      else begin
         assert_fails++;
         $error("response line changed while stalled");
      end

   // Settings strobe is a single cycle pulse
   stb_pulse: assert property (@(posedge clk) disable iff (reset_i)
      set_stb_i |=> !set_stb_i)
      else begin
         assert_fails++;
         $error("settings strobe high for two cycles");
      end

   // One packet in flight
   one_packet: assert property (@(posedge clk) disable iff (reset_i)
      resp_valid_i |-> !cmd_ready_i)
      else begin
         assert_fails++;
         $error("command ready while a response is pending");
      end

endmodule

bind radio_ctrl_core radio_ctrl_core_assert radio_ctrl_core_assert_i (
   .clk(clk),
   .reset_i(reset_i),
   .cmd_ready_i(cmd_ready_o),
   .resp_data_i(resp_data_o),
   .resp_valid_i(resp_valid_o),
   .resp_ready_i(resp_ready_i),
   .set_stb_i(set_stb)
);

//--- tb/radio_ctrl_core_tb.sv
`timescale 1ns/1ps

module radio_ctrl_core_tb import ctrl_pkg::*; ();

   localparam int          GPIO_W  = 16;
   localparam logic [31:0] COMPAT  = 32'h000b_0002;
   localparam int          TIMEOUT = 200;

   logic              clk;
   logic              reset_i;
   logic [35:0]       cmd_data_i;
   logic              cmd_valid_i;
   logic              cmd_ready_o;
   logic [35:0]       resp_data_o;
   logic              resp_valid_o;
   logic              resp_ready_i;
   logic              pps_i;
   logic              run_rx_i;
   logic              run_tx_i;
   logic [GPIO_W-1:0] gpio_i;
   logic [GPIO_W-1:0] gpio_o;
   logic [GPIO_W-1:0] gpio_oe_o;
   logic              clock_sync_o;
   logic [63:0]       vita_time_o;

   logic [31:0] lcg_state = 32'ha969_cd39;
   logic [13:0] seq_num   = '0;
   bit          heavy_bp  = 1'b0;
   string       test_name = "reset";
   int          checks    = 0;
   int          errors    = 0;
   int          test_errs = 0;
   logic [31:0] cfg0;
   logic [31:0] cfg1;

   radio_ctrl_core #(.GPIO_WIDTH(GPIO_W), .COMPAT_NUM(COMPAT)) radio_ctrl_core_i (
      .clk(clk), .reset_i(reset_i),
      .cmd_data_i(cmd_data_i), .cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o),
      .resp_data_o(resp_data_o), .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i),
      .pps_i(pps_i), .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o),
      .clock_sync_o(clock_sync_o), .vita_time_o(vita_time_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic count_fail();
      errors++;
      test_errs++;
   endtask

   task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         count_fail();
         $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_hdr(input string what, input ctrl_word_u exp, input ctrl_word_u act);
      checks++;
      if (act !== exp) begin
         count_fail();
         $display("[FAIL] %s %s: expected %h (op %0d seq %0d), actual %h (op %0d seq %0d)",
                  test_name, what, exp, exp.wr.op, exp.wr.seq, act, act.wr.op, act.wr.seq);
      end
   endtask

   task automatic check_gpio(input string what, input logic [GPIO_W-1:0] exp,
                             input logic [GPIO_W-1:0] act);
      checks++;
      if (act !== exp) begin
         count_fail();
         $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         count_fail();
         $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   // Time values only have a window, lo inclusive and hi exclusive
   task automatic check_range(input string what, input logic [63:0] lo, input logic [63:0] hi,
                              input logic [63:0] act);
      checks++;
      if ($isunknown(act) || act < lo || act >= hi) begin
         count_fail();
         $display("[FAIL] %s %s: expected [%h, %h), actual %h", test_name, what, lo, hi, act);
      end
   endtask

   task automatic report_error(input string msg);
      count_fail();
      $display("%s: %s", test_name, msg);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stream drivers
   ////////////////////////////////////////////////////////////////////////////

   // Entered and left on a falling edge
   task automatic push_line(input logic [35:0] line);
      int waited;
      waited = 0;
      cmd_data_i  = line;
      cmd_valid_i = 1'b1;
      while (!cmd_ready_o && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!cmd_ready_o) begin
         report_error("timeout waiting for cmd_ready_o");
      end
      @(negedge clk);
      cmd_valid_i = 1'b0;
   endtask

   task automatic send_cmd(input ctrl_word_u cmd, input logic [31:0] data);
      logic [35:0] line;
      line           = '0;
      line[LINE_SOF] = 1'b1;
      line[31:0]     = cmd;
      push_line(line);
      line           = '0;
      line[LINE_EOF] = 1'b1;
      line[31:0]     = data;
      push_line(line);
   endtask

   task automatic get_resp(output logic [35:0] line0, output logic [35:0] line1, output bit ok);
      logic [31:0] r;
      int          got;
      int          waited;
      got    = 0;
      waited = 0;
      line0  = '0;
      line1  = '0;
      while (got < 2 && waited < TIMEOUT) begin
         r = next_rand();
         resp_ready_i = heavy_bp ? r[31] : (r[31:30] != 2'b00);
         if (resp_valid_o && resp_ready_i) begin
            if (got == 0) begin
               line0 = resp_data_o;
            end else begin
               line1 = resp_data_o;
            end
            got++;
         end
         @(negedge clk);
         waited++;
      end
      resp_ready_i = 1'b0;
      ok = (got == 2);
      if (!ok) begin
         report_error("timeout waiting for both response lines");
      end
   endtask

   task automatic transact(input ctrl_word_u cmd, input logic [31:0] data,
                           output logic [31:0] val);
      ctrl_word_u  word;
      ctrl_word_u  exp_hdr;
      ctrl_word_u  got_hdr;
      logic [35:0] line0;
      logic [35:0] line1;
      bit          ok;
      word        = cmd;
      word.wr.seq = seq_num;
      seq_num     = seq_num + 14'd1;
      exp_hdr        = '0;
      exp_hdr.wr.op  = word.wr.op;
      exp_hdr.wr.seq = word.wr.seq;
      send_cmd(word, data);
      // Header is due one cycle after the EOF line
      check_bit("response latency", 1'b1, resp_valid_o);
      get_resp(line0, line1, ok);
      val = line1[31:0];
      if (ok) begin
         got_hdr = line0[31:0];
         check_hdr("response header", exp_hdr, got_hdr);
         check_bit("header SOF", 1'b1, line0[LINE_SOF]);
         check_bit("data EOF", 1'b1, line1[LINE_EOF]);
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      ctrl_word_u  cmd;
      logic [31:0] val;
      cmd         = '0;
      cmd.wr.op   = OP_WRITE;
      cmd.wr.addr = addr;
      transact(cmd, data, val);
      check_word("write ack", 32'h0, val);
   endtask

   task automatic read_rb(input logic [3:0] sel, output logic [31:0] val);
      ctrl_word_u cmd;
      cmd           = '0;
      cmd.rd.op     = OP_READ;
      cmd.rd.rb_sel = sel;
      transact(cmd, next_rand(), val);
   endtask

   task automatic read_time(output logic [63:0] t);
      logic [31:0] hi;
      logic [31:0] lo;
      read_rb(RB_TIME_HI, hi);
      read_rb(RB_TIME_LO, lo);
      t = {hi, lo};
   endtask

   task automatic read_pps(output logic [63:0] t);
      logic [31:0] hi;
      logic [31:0] lo;
      read_rb(RB_PPS_HI, hi);
      read_rb(RB_PPS_LO, lo);
      t = {hi, lo};
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic apply_reset();
      reset_i      = 1'b1;
      cmd_valid_i  = 1'b0;
      resp_ready_i = 1'b0;
      idle(5);
      check_bit("cmd_ready_o in reset", 1'b1, cmd_ready_o);
      check_bit("resp_valid_o in reset", 1'b0, resp_valid_o);
      check_bit("clock_sync_o in reset", 1'b0, clock_sync_o);
      check_gpio("gpio_oe_o in reset", '0, gpio_oe_o);
      check_range("time in reset", 64'd0, 64'd1, vita_time_o);
      reset_i = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      $display("test %s finished with %0d errors", test_name, test_errs);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_config();
      logic [31:0] v;
      start_test("config");
      cfg0 = next_rand();
      cfg1 = next_rand();
      write_reg(SR_MISC + 8'd0, cfg0);
      write_reg(SR_MISC + 8'd1, cfg1);
      read_rb(RB_CONFIG0, v);
      check_word("config0", cfg0, v);
      read_rb(RB_CONFIG1, v);
      check_word("config1", cfg1, v);
      // Config words survive a core reset
      apply_reset();
      read_rb(RB_CONFIG0, v);
      check_word("config0 after reset", cfg0, v);
      read_rb(RB_CONFIG1, v);
      check_word("config1 after reset", cfg1, v);
      read_rb(RB_COMPAT, v);
      check_word("compat number", COMPAT, v);
      end_test();
   endtask

   task automatic test_gpio();
      logic [GPIO_W-1:0] atr_val [4];
      logic [GPIO_W-1:0] mask;
      logic [31:0]       r;
      logic [31:0]       v;
      logic [1:0]        sel;
      start_test("gpio_atr");
      for (int k = 0; k < 4; k++) begin
         r      = next_rand();
         r[1:0] = k[1:0];
         atr_val[k] = r[GPIO_W-1:0];
         write_reg(SR_GPIO + 8'(k), {{(32-GPIO_W){1'b0}}, atr_val[k]});
      end
      r    = next_rand();
      mask = r[31:32-GPIO_W];
      write_reg(SR_GPIO + 8'd4, {{(32-GPIO_W){1'b0}}, mask});
      // Idle, rx only, tx only, full duplex
      for (int k = 0; k < 4; k++) begin
         sel      = k[1:0];
         run_rx_i = sel[0];
         run_tx_i = sel[1];
         idle(3);
         check_gpio("gpio_o for run state", atr_val[k], gpio_o);
         check_gpio("gpio_oe_o", mask, gpio_oe_o);
      end
      run_rx_i = 1'b0;
      run_tx_i = 1'b0;
      r      = next_rand();
      gpio_i = r[GPIO_W-1:0];
      idle(2);
      read_rb(RB_GPIO, v);
      check_word("gpio readback", {{(32-GPIO_W){1'b0}}, r[GPIO_W-1:0]}, v);
      end_test();
   endtask

   task automatic test_time_now();
      logic [63:0] load;
      logic [63:0] t1;
      logic [63:0] t2;
      start_test("time_set_now");
      load = {next_rand() & 32'h00ff_ffff, next_rand()};
      write_reg(SR_TIME64 + 8'd0, load[63:32]);
      write_reg(SR_TIME64 + 8'd1, load[31:0]);
      write_reg(SR_TIME64 + 8'd2, 32'h1);
      read_time(t1);
      check_range("first time read", load, load + 64'd100, t1);
      read_time(t2);
      check_range("second time read", t1 + 64'd1, t1 + 64'd100, t2);
      end_test();
   endtask

   task automatic test_pps();
      logic [63:0] t0;
      logic [63:0] t1;
      logic [63:0] t2;
      logic [63:0] armed;
      logic [63:0] latch;
      start_test("pps");
      read_time(t0);
      armed = {t0[63:32] + 32'd1, next_rand()};
      write_reg(SR_TIME64 + 8'd0, armed[63:32]);
      write_reg(SR_TIME64 + 8'd1, armed[31:0]);
      write_reg(SR_TIME64 + 8'd2, 32'h0);
      read_time(t1);
      check_range("time while armed", t0, armed, t1);
      // Synchronizer plus edge detect need three cycles
      pps_i = 1'b1;
      idle(6);
      pps_i = 1'b0;
      idle(6);
      // Latch lands within 10 of the armed value
      read_pps(latch);
      check_range("pps latch", armed - 64'd10, armed + 64'd11, latch);
      read_time(t2);
      check_range("time after pps", armed, armed + 64'd100, t2);
      end_test();
   endtask

   task automatic test_framing();
      logic [35:0] stray;
      ctrl_word_u  cmd;
      logic [31:0] v;
      logic [31:0] data;
      start_test("framing");
      stray       = '0;
      stray[31:0] = next_rand();
      push_line(stray);
      read_rb(RB_CONFIG0, v);
      check_word("read after stray line", cfg0, v);
      // Op 3 decodes as neither write nor read
      cmd         = '0;
      cmd.wr.op   = 2'd3;
      cmd.wr.addr = SR_MISC;
      transact(cmd, ~cfg0, v);
      check_word("unknown op value", 32'hffff_ffff, v);
      read_rb(RB_CONFIG0, v);
      check_word("config0 after unknown op", cfg0, v);
      heavy_bp = 1'b1;
      for (int i = 0; i < 6; i++) begin
         data = next_rand();
         write_reg(SR_MISC + 8'd1, data);
         read_rb(RB_CONFIG1, v);
         check_word("config1 under back-pressure", data, v);
         cfg1 = data;
      end
      heavy_bp = 1'b0;
      end_test();
   endtask

   task automatic test_clock_sync();
      logic lvl;
      start_test("clock_sync");
      // Gated off after reset even with the pin high
      pps_i = 1'b1;
      apply_reset();
      check_bit("clock_sync_o after reset", 1'b0, clock_sync_o);
      write_reg(SR_MISC + 8'd2, 32'h1);
      for (int i = 0; i < 2; i++) begin
         lvl   = i[0];
         pps_i = lvl;
         idle(1);
         check_bit("clock_sync_o follows pps", lvl, clock_sync_o);
      end
      write_reg(SR_MISC + 8'd2, 32'h3);
      for (int i = 0; i < 2; i++) begin
         lvl   = i[0];
         pps_i = lvl;
         idle(1);
         check_bit("clock_sync_o inverted", ~lvl, clock_sync_o);
      end
      pps_i = 1'b0;
      end_test();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int afails;
      reset_i      = 1'b1;
      cmd_data_i   = '0;
      cmd_valid_i  = 1'b0;
      resp_ready_i = 1'b0;
      pps_i        = 1'b0;
      run_rx_i     = 1'b0;
      run_tx_i     = 1'b0;
      gpio_i       = '0;
      apply_reset();
      end_test();
      test_config();
      test_gpio();
      test_time_now();
      test_pps();
      test_framing();
      test_clock_sync();
      idle(2);
      afails = radio_ctrl_core_i.radio_ctrl_core_assert_i.assert_fails;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
      if (errors == 0 && afails == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
